//--- rtl/control_unit.sv
// Control unit, opcode class, ALU operation, source usage and illegal flag
`timescale 1ns/10ps

module control_unit (
	input  logic [31:0]              i_instr, // Fetched instruction word
	output rv_decode_pkg::dec_ctrl_t o_ctrl   // Decoded control
);

	logic [2:0] func3;
	logic [6:0] func7;
	logic       f7_zero; // func7 == 0000000
	logic       f7_alt;  // func7 == 0100000, SUB and SRA

	assign func3   = i_instr[14:12];
	assign func7   = i_instr[31:25];
	assign f7_zero = (func7 == 7'b0000000);
	assign f7_alt  = (func7 == 7'b0100000);

	// Shared func3 table for OP and OP_IMM, alt picks SUB/SRA
	function automatic rv_decode_pkg::alu_op_e alu_from_func3(input logic [2:0] f3,
			input logic alt);
		case (f3)
			3'b000:  return alt ? rv_decode_pkg::SUB : rv_decode_pkg::ADD;
			3'b001:  return rv_decode_pkg::SLL;
			3'b010:  return rv_decode_pkg::SLT;
			3'b011:  return rv_decode_pkg::SLTU;
			3'b100:  return rv_decode_pkg::XOR;
			3'b101:  return alt ? rv_decode_pkg::SRA : rv_decode_pkg::SRL;
			3'b110:  return rv_decode_pkg::OR;
			default: return rv_decode_pkg::AND;
		endcase
	endfunction

	always_comb begin
		o_ctrl.opcode   = rv_decode_pkg::opcode_e'(i_instr[6:0]); // Raw field passes through
		o_ctrl.func3    = func3;
		o_ctrl.alu_op   = rv_decode_pkg::ADD; // Address and PC arithmetic
		o_ctrl.uses_rs1 = 1'b0;
		o_ctrl.uses_rs2 = 1'b0;
		o_ctrl.illegal  = 1'b0;
		case (i_instr[6:0])
			rv_decode_pkg::LUI:   o_ctrl.alu_op = rv_decode_pkg::PASS_B;
			rv_decode_pkg::AUIPC,
			rv_decode_pkg::JAL: ; // ADD, no register sources
			rv_decode_pkg::JALR: begin
				o_ctrl.uses_rs1 = 1'b1;
				o_ctrl.illegal  = (func3 != 3'b000);
			end
			rv_decode_pkg::BRANCH: begin
				o_ctrl.alu_op   = rv_decode_pkg::SUB; // Compare by subtraction
				o_ctrl.uses_rs1 = 1'b1;
				o_ctrl.uses_rs2 = 1'b1;
				o_ctrl.illegal  = (func3 == 3'b010) || (func3 == 3'b011);
			end
			rv_decode_pkg::LOAD: begin
				o_ctrl.uses_rs1 = 1'b1;
				o_ctrl.illegal  = (func3 == 3'b011) || (func3[2:1] == 2'b11); // No LD/LWU
			end
			rv_decode_pkg::STORE: begin
				o_ctrl.uses_rs1 = 1'b1;
				o_ctrl.uses_rs2 = 1'b1;
				o_ctrl.illegal  = (func3 > 3'b010); // SB, SH, SW only
			end
			rv_decode_pkg::OP_IMM: begin
				o_ctrl.uses_rs1 = 1'b1;
				o_ctrl.alu_op   = alu_from_func3(func3, (func3 == 3'b101) && func7[5]);
				if (func3 == 3'b001) begin
					o_ctrl.illegal = !f7_zero;              // SLLI
				end else if (func3 == 3'b101) begin
					o_ctrl.illegal = !(f7_zero || f7_alt); // SRLI/SRAI
				end
			end
			rv_decode_pkg::OP: begin
				o_ctrl.uses_rs1 = 1'b1;
				o_ctrl.uses_rs2 = 1'b1;
				o_ctrl.alu_op   = alu_from_func3(func3, func7[5]);
				// Alternate encoding only exists for SUB and SRA
				o_ctrl.illegal  = !(f7_zero || (f7_alt && (func3 == 3'b000 || func3 == 3'b101)));
			end
			default: o_ctrl.illegal = 1'b1; // CSR, fence, system and unknown
		endcase
	end

endmodule

//--- rtl/decode_stage.sv
// Decode stage, register read request, credit counter, fetch stall and output register
`timescale 1ns/10ps

module decode_stage #(
	parameter int EX_CREDITS = 2 // Execute buffer depth, 1 to 15
) (
	input  logic                            clk,
	input  logic                            rst_n,
	// Fetch side
	input  logic [31:0]                     i_if_instr,  // Instruction word
	input  logic [rv_decode_pkg::PC_W-1:0]  i_if_pc,     // Its PC
	input  logic                            i_if_valid,  // Packet present
	output logic                            o_if_stall,  // No credit, hold the packet
	// Register file
	reg_read_if.requester                   rd,
	// Side-by-side decoders
	input  logic [rv_decode_pkg::XLEN-1:0]  i_imm,       // From imm_gen
	input  rv_decode_pkg::dec_ctrl_t        i_ctrl,      // From control_unit
	// Execute side
	input  logic                            i_ex_credit, // One pulse per freed slot
	output logic [rv_decode_pkg::XLEN-1:0]  o_rs1_data,
	output logic [rv_decode_pkg::XLEN-1:0]  o_rs2_data,
	output logic [rv_decode_pkg::XLEN-1:0]  o_imm,
	output rv_decode_pkg::dec_ctrl_t        o_ctrl,
	output logic [rv_decode_pkg::PC_W-1:0]  o_pc,
	output logic                            o_id_valid   // One cycle per accepted instruction
);

	localparam int CNT_W = $clog2(EX_CREDITS + 1); // Holds 0..EX_CREDITS

	logic [CNT_W-1:0]               credit_cnt; // Free slots in execute
	logic                           accept;     // Instruction consumed this cycle
	logic [rv_decode_pkg::XLEN-1:0] rs1_val;    // Read data, zero when unused
	logic [rv_decode_pkg::XLEN-1:0] rs2_val;

	// Register read request straight from the instruction fields
	assign rd.rs1_addr = i_if_instr[19:15];
	assign rd.rs2_addr = i_if_instr[24:20];
	assign rd.rd_en    = i_ctrl.uses_rs1 | i_ctrl.uses_rs2; // LUI, AUIPC, JAL skip the file

	// Per-source masking, a shared enable still returns both ports
	assign rs1_val = i_ctrl.uses_rs1 ? rd.rs1_data : '0;
	assign rs2_val = i_ctrl.uses_rs2 ? rd.rs2_data : '0;

	assign o_if_stall = (credit_cnt == '0);
	assign accept     = i_if_valid && !o_if_stall;

	// Acceptance spends a credit, a returned credit refunds one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= CNT_W'(EX_CREDITS); // Execute buffer starts empty
		end else begin
			case ({accept, i_ex_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt; // Idle, or both cancel
			endcase
		end
	end

	// Valid is a single-cycle pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_id_valid <= 1'b0;
		end else begin
			o_id_valid <= accept;
		end
	end

	// Payload loads only on acceptance, holds otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_rs1_data      <= '0;
			o_rs2_data      <= '0;
			o_imm           <= '0;
			o_pc            <= '0;
			o_ctrl.opcode   <= rv_decode_pkg::opcode_e'(7'b0);
			o_ctrl.func3    <= '0;
			o_ctrl.alu_op   <= rv_decode_pkg::ADD;
			o_ctrl.uses_rs1 <= 1'b0;
			o_ctrl.uses_rs2 <= 1'b0;
			o_ctrl.illegal  <= 1'b0;
		end else if (accept) begin
			o_rs1_data <= rs1_val;
			o_rs2_data <= rs2_val;
			o_imm      <= i_imm;
			o_pc       <= i_if_pc;
			o_ctrl     <= i_ctrl;
		end
	end

endmodule

//--- rtl/decode_top.sv
// Decode top level, register file, immediate generator, control unit and decode stage
`timescale 1ns/10ps

module decode_top #(
	parameter int EX_CREDITS = 2 // Execute buffer depth, 1 to 15
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	// Fetch
	input  logic [31:0]                          i_if_instr,
	input  logic [rv_decode_pkg::PC_W-1:0]       i_if_pc,
	input  logic                                 i_if_valid,
	output logic                                 o_if_stall,
	// Write-back
	input  logic                                 i_wr_en,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] i_wr_addr,
	input  logic [rv_decode_pkg::XLEN-1:0]       i_wr_data,
	// Execute
	input  logic                                 i_ex_credit,
	output logic [rv_decode_pkg::XLEN-1:0]       o_rs1_data,
	output logic [rv_decode_pkg::XLEN-1:0]       o_rs2_data,
	output logic [rv_decode_pkg::XLEN-1:0]       o_imm,
	output logic [6:0]                           o_opcode,
	output logic [2:0]                           o_func3,
	output logic [3:0]                           o_alu_op,
	output logic                                 o_illegal,
	output logic [rv_decode_pkg::PC_W-1:0]       o_pc,
	output logic                                 o_id_valid
);

	reg_read_if rd_if (); // Decode to register file read path

	logic [rv_decode_pkg::XLEN-1:0] dec_imm;  // Combinational immediate
	rv_decode_pkg::dec_ctrl_t       dec_ctrl; // Combinational control
	rv_decode_pkg::dec_ctrl_t       id_ctrl;  // Registered control

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.rd        (rd_if.file)
	);

	// Both decoders see the same fetched word
	imm_gen u_imm_gen (
		.i_instr (i_if_instr),
		.o_imm   (dec_imm)
	);

	control_unit u_control_unit (
		.i_instr (i_if_instr),
		.o_ctrl  (dec_ctrl)
	);

	decode_stage #(
		.EX_CREDITS (EX_CREDITS)
	) u_decode_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_if_instr  (i_if_instr),
		.i_if_pc     (i_if_pc),
		.i_if_valid  (i_if_valid),
		.o_if_stall  (o_if_stall),
		.rd          (rd_if.requester),
		.i_imm       (dec_imm),
		.i_ctrl      (dec_ctrl),
		.i_ex_credit (i_ex_credit),
		.o_rs1_data  (o_rs1_data),
		.o_rs2_data  (o_rs2_data),
		.o_imm       (o_imm),
		.o_ctrl      (id_ctrl),
		.o_pc        (o_pc),
		.o_id_valid  (o_id_valid)
	);

	// Flatten the control struct for execute
	assign o_opcode  = id_ctrl.opcode;
	assign o_func3   = id_ctrl.func3;
	assign o_alu_op  = id_ctrl.alu_op;
	assign o_illegal = id_ctrl.illegal;

endmodule

//--- rtl/imm_gen.sv
// Immediate generator, picks the I/S/B/U/J format from the opcode and sign-extends
`timescale 1ns/10ps

module imm_gen (
	input  logic [31:0]                     i_instr, // Fetched instruction word
	output logic [rv_decode_pkg::XLEN-1:0]  o_imm    // Sign-extended immediate
);

	typedef enum logic [2:0] {
		FMT_NONE, // R-type and illegal opcodes
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} imm_fmt_e;

	imm_fmt_e fmt;

	// Format from the major opcode
	always_comb begin
		case (i_instr[6:0])
			rv_decode_pkg::LOAD,
			rv_decode_pkg::OP_IMM,
			rv_decode_pkg::JALR:   fmt = FMT_I;
			rv_decode_pkg::STORE:  fmt = FMT_S;
			rv_decode_pkg::BRANCH: fmt = FMT_B;
			rv_decode_pkg::LUI,
			rv_decode_pkg::AUIPC:  fmt = FMT_U;
			rv_decode_pkg::JAL:    fmt = FMT_J;
			default:               fmt = FMT_NONE; // OP has no immediate
		endcase
	end

	// Bit 31 is the sign in every format
	always_comb begin
		case (fmt)
			FMT_I:   o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
			FMT_S:   o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			FMT_B:   o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
					i_instr[30:25], i_instr[11:8], 1'b0}; // Halfword aligned
			FMT_U:   o_imm = {i_instr[31:12], 12'b0};
			FMT_J:   o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
					i_instr[20], i_instr[30:21], 1'b0};
			default: o_imm = '0;
		endcase
	end

endmodule

//--- rtl/reg_file.sv
// 32-entry register file, two combinational read ports, one write port with bypass
`timescale 1ns/10ps

module reg_file (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 i_wr_en,   // Write-back strobe
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] i_wr_addr, // Destination index
	input  logic [rv_decode_pkg::XLEN-1:0]       i_wr_data, // Write-back value
	reg_read_if.file                             rd
);

	logic [rv_decode_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

	logic wr_ok;      // Write to a real register
	logic byp_rs1;    // Same-cycle write hits rs1
	logic byp_rs2;    // Same-cycle write hits rs2

	assign wr_ok   = i_wr_en && (i_wr_addr != '0); // Writes to x0 are dropped
	assign byp_rs1 = wr_ok && (i_wr_addr == rd.rs1_addr);
	assign byp_rs2 = wr_ok && (i_wr_addr == rd.rs2_addr);

	// Storage clears on reset, write lands at the rising edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// Read port 1, x0 and disabled reads give zero
	always_comb begin
		if (!rd.rd_en || (rd.rs1_addr == '0)) begin
			rd.rs1_data = '0;
		end else if (byp_rs1) begin
			rd.rs1_data = i_wr_data;            // Write-through
		end else begin
			rd.rs1_data = regs[rd.rs1_addr];
		end
	end

	// Read port 2, same rules
	always_comb begin
		if (!rd.rd_en || (rd.rs2_addr == '0)) begin
			rd.rs2_data = '0;
		end else if (byp_rs2) begin
			rd.rs2_data = i_wr_data;            // Write-through
		end else begin
			rd.rs2_data = regs[rd.rs2_addr];
		end
	end

endmodule

//--- rtl/reg_read_if.sv
// Register file read bundle with requester and file modports
`timescale 1ns/10ps

interface reg_read_if;

	logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr; // Source register 1 index
	logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr; // Source register 2 index
	logic                                 rd_en;    // Read enable, data is zero when low
	logic [rv_decode_pkg::XLEN-1:0]       rs1_data; // Same-cycle read data
	logic [rv_decode_pkg::XLEN-1:0]       rs2_data;

	// Decode side drives the request
	modport requester (
		output rs1_addr, rs2_addr, rd_en,
		input  rs1_data, rs2_data
	);

	// Register file answers combinationally
	modport file (
		input  rs1_addr, rs2_addr, rd_en,
		output rs1_data, rs2_data
	);

endinterface

//--- rtl/rv_decode_pkg.sv
// RV32I decode widths, major opcode and ALU operation enums, decoded control struct
package rv_decode_pkg;

	localparam int XLEN       = 32; // Register and immediate width
	localparam int REG_ADDR_W = 5;  // x0..x31
	localparam int PC_W       = 32; // Program counter width

	// Major opcode field, bits [6:0] of the instruction word
	typedef enum logic [6:0] {
		LUI    = 7'b0110111, // U-type
		AUIPC  = 7'b0010111, // U-type, PC relative
		JAL    = 7'b1101111, // J-type
		JALR   = 7'b1100111, // I-type jump
		BRANCH = 7'b1100011, // B-type
		LOAD   = 7'b0000011, // I-type
		STORE  = 7'b0100011, // S-type
		OP_IMM = 7'b0010011, // I-type ALU
		OP     = 7'b0110011  // R-type ALU
	} opcode_e;

	// ALU operation handed to execute
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		PASS_B = 4'd10 // Operand B straight through, used by LUI
	} alu_op_e;

	// Control unit result, 17 bits
	typedef struct packed {
		opcode_e    opcode;   // Raw opcode field, may hold a non-member when illegal
		logic [2:0] func3;    // Passed on for branch and memory width selection
		alu_op_e    alu_op;
		logic       uses_rs1; // Instruction reads rs1
		logic       uses_rs2; // Instruction reads rs2
		logic       illegal;  // Outside the supported RV32I subset
	} dec_ctrl_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal --top-module tb_decode \
	-f sources.f -o sim_decode

./obj_dir/sim_decode | tee sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

//--- sources.f
rtl/rv_decode_pkg.sv
rtl/reg_read_if.sv
rtl/reg_file.sv
rtl/imm_gen.sv
rtl/control_unit.sv
rtl/decode_stage.sv
rtl/decode_top.sv
testbench/decode_assertions.sv
testbench/tb_decode.sv

//--- testbench/decode_assertions.sv
// Concurrent checks on reset, valid pulses and credit accounting, bound into decode_top
`timescale 1ns/10ps

module decode_assertions #(
	parameter int EX_CREDITS = 2 // Execute buffer depth
) (
	input logic clk,
	input logic rst_n,
	input logic i_if_stall,  // DUT o_if_stall
	input logic i_ex_credit, // Returned credit pulse
	input logic i_id_valid   // DUT o_id_valid
);

	int in_flight; // Valid pulses not yet answered by a credit

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_flight <= 0;
		end else begin
			in_flight <= in_flight + int'(i_id_valid) - int'(i_ex_credit);
		end
	end

	// Output register starts empty
	a_valid_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !i_id_valid)
		else $error("o_id_valid high in the first cycle after reset");

	// Nothing is accepted while stalled
	a_no_valid_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
		i_id_valid |-> !$past(i_if_stall))
		else $error("o_id_valid pulsed after a stalled cycle");

	// Execute buffer never overfills
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		in_flight <= EX_CREDITS)
		else $error("More instructions in flight than execute credits");

endmodule

bind decode_top decode_assertions #(
	.EX_CREDITS (EX_CREDITS)
) u_decode_assertions (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_if_stall  (o_if_stall),
	.i_ex_credit (i_ex_credit),
	.i_id_valid  (o_id_valid)
);

//--- testbench/tb_decode.sv
// Decode testbench with clock, reset, LFSR, reference models and directed tests
`timescale 1ns/10ps

module tb_decode;

	localparam int TIMEOUT = 50; // Cycle limit for any single wait
	localparam int N_STREAM = 40; // Instructions in the credit stream

	logic        clk;
	logic        rst_n;
	logic [31:0] if_instr;
	logic [31:0] if_pc;
	logic [31:0] wr_data;
	logic [31:0] ex_rs1;
	logic [31:0] ex_rs2;
	logic [31:0] imm;
	logic [31:0] pc;
	logic        if_valid;
	logic        if_stall;
	logic        wr_en;
	logic        ex_credit;
	logic        illegal;
	logic        id_valid;
	logic [4:0]  wr_addr;
	logic [6:0]  opcode;
	logic [2:0]  func3;
	logic [3:0]  alu_op;

	logic [31:0] model_regs [32]; // Expected register file contents
	logic [31:0] lfsr;            // Random state
	int          checks;
	int          errors;

	decode_top #(
		.EX_CREDITS (2)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_if_instr  (if_instr),
		.i_if_pc     (if_pc),
		.i_if_valid  (if_valid),
		.o_if_stall  (if_stall),
		.i_wr_en     (wr_en),
		.i_wr_addr   (wr_addr),
		.i_wr_data   (wr_data),
		.i_ex_credit (ex_credit),
		.o_rs1_data  (ex_rs1),
		.o_rs2_data  (ex_rs2),
		.o_imm       (imm),
		.o_opcode    (opcode),
		.o_func3     (func3),
		.o_alu_op    (alu_op),
		.o_illegal   (illegal),
		.o_pc        (pc),
		.o_id_valid  (id_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// RV32I immediate formats
	function automatic logic [31:0] imm_model(input logic [31:0] in);
		logic [31:0] v;
		v = '0;
		case (in[6:0])
			7'b0010011, 7'b0000011, 7'b1100111: v = 32'($signed(in) >>> 20); // I
			7'b0100011: begin
				v      = 32'($signed(in) >>> 20); // S keeps the I upper bits
				v[4:0] = in[11:7];
			end
			7'b1100011: v = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};    // B
			7'b0110111, 7'b0010111: v = {in[31:12], 12'h000};                  // U
			7'b1101111: v = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0}; // J
			default: ;
		endcase
		return v;
	endfunction

	function automatic logic [3:0] alu_op_model(input logic [31:0] in);
		logic [2:0] f3;
		logic       alt;
		f3  = in[14:12];
		alt = in[30] && (in[6:0] == 7'b0110011 || f3 == 3'b101); // SUB only on OP
		case (in[6:0])
			7'b0110111: return rv_decode_pkg::PASS_B; // LUI
			7'b1100011: return rv_decode_pkg::SUB;    // Branch compare
			7'b0110011, 7'b0010011: begin
				case (f3)
					3'b000:  return alt ? rv_decode_pkg::SUB : rv_decode_pkg::ADD;
					3'b001:  return rv_decode_pkg::SLL;
					3'b010:  return rv_decode_pkg::SLT;
					3'b011:  return rv_decode_pkg::SLTU;
					3'b100:  return rv_decode_pkg::XOR;
					3'b101:  return alt ? rv_decode_pkg::SRA : rv_decode_pkg::SRL;
					3'b110:  return rv_decode_pkg::OR;
					default: return rv_decode_pkg::AND;
				endcase
			end
			default: return rv_decode_pkg::ADD;
		endcase
	endfunction

	function automatic logic illegal_model(input logic [31:0] in);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = in[14:12];
		f7 = in[31:25];
		case (in[6:0])
			7'b0110111, 7'b0010111, 7'b1101111: return 1'b0;
			7'b1100111: return f3 != 3'd0;
			7'b1100011: return f3 inside {3'd2, 3'd3};
			7'b0000011: return !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
			7'b0100011: return f3 > 3'd2;
			7'b0010011: return (f3 == 3'd1 && f7 != 7'h00) ||
				(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
			7'b0110011: return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
			default: return 1'b1; // Fence, system, unknown
		endcase
	endfunction

	// Source usage as {rs1, rs2}
	function automatic logic [1:0] source_usage(input logic [6:0] op);
		case (op)
			7'b1100011, 7'b0100011, 7'b0110011: return 2'b11;
			7'b1100111, 7'b0000011, 7'b0010011: return 2'b10;
			default: return 2'b00;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic confirm(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Failure at %0t: %s", $time, what);
		end
	endtask

	task automatic wait_valid(output int waited);
		int n;
		for (n = 0; n < TIMEOUT && !id_valid; n++) begin
			@(posedge clk);
			#1;
		end
		waited = n;
		confirm(id_valid, "timed out waiting for o_id_valid");
	endtask

	// Present one instruction, wait for it, then free its execute slot
	task automatic issue(input logic [31:0] instr, input logic [31:0] pc_in);
		int   n;
		int   late;
		logic stalled;
		if_instr = instr;
		if_pc    = pc_in;
		if_valid = 1'b1;
		stalled  = 1'b1;
		for (n = 0; n < TIMEOUT && stalled; n++) begin
			stalled = if_stall; // Stall before the edge decides acceptance
			@(posedge clk);
			#1;
		end
		if_valid = 1'b0;
		confirm(!stalled, "instruction was never accepted");
		wait_valid(late);
		confirm(late == 0, "o_id_valid did not follow acceptance by one cycle");
		ex_credit = 1'b1;
		@(posedge clk);
		#1;
		ex_credit = 1'b0;
	endtask

	task automatic decode_and_compare(input logic [31:0] instr, input logic [31:0] pc_in);
		logic [1:0]  uses;
		logic [31:0] e_rs1;
		logic [31:0] e_rs2;
		uses  = source_usage(instr[6:0]);
		e_rs1 = uses[1] ? model_regs[instr[19:15]] : '0; // Unused source reads zero
		e_rs2 = uses[0] ? model_regs[instr[24:20]] : '0;
		issue(instr, pc_in);
		compare("o_rs1_data", ex_rs1, e_rs1);
		compare("o_rs2_data", ex_rs2, e_rs2);
		compare("o_imm", imm, imm_model(instr));
		compare("o_opcode", 32'(opcode), 32'(instr[6:0]));
		compare("o_func3", 32'(func3), 32'(instr[14:12]));
		compare("o_alu_op", 32'(alu_op), 32'(alu_op_model(instr)));
		compare("o_illegal", 32'(illegal), 32'(illegal_model(instr)));
		compare("o_pc", pc, pc_in);
	endtask

	task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
		wr_en   = 1'b1;
		wr_addr = a;
		wr_data = d;
		@(posedge clk);
		#1;
		wr_en = 1'b0;
		if (a != 5'd0) model_regs[a] = d; // x0 ignores writes
	endtask

	task automatic reset_state();
		compare("o_id_valid", 32'(id_valid), 32'd0);
		compare("o_if_stall", 32'(if_stall), 32'd0);
		for (int r = 0; r < 32; r++) begin
			decode_and_compare({7'h00, 5'(31 - r), 5'(r), 3'b000, 5'd1, 7'b0110011},
				32'(r * 4));
		end
	endtask

	task automatic regfile_access();
		logic [4:0]  a;
		logic [31:0] d;
		for (int k = 0; k < 8; k++) begin
			a = 5'(rand_bits(5));
			d = rand_bits(32);
			write_reg(a, d);
			decode_and_compare({7'h00, 5'(rand_bits(5)), a, 3'b000, 5'd2, 7'b0110011},
				32'h100 + 32'(k * 4));
		end
		write_reg(5'd0, 32'hdeadbeef);
		decode_and_compare({7'h00, 5'd0, 5'd0, 3'b000, 5'd3, 7'b0110011}, 32'h200);
		wr_en         = 1'b1; // Same-cycle write and read of x7
		wr_addr       = 5'd7;
		wr_data       = rand_bits(32);
		model_regs[7] = wr_data;
		decode_and_compare({7'h00, 5'd7, 5'd7, 3'b000, 5'd4, 7'b0110011}, 32'h204);
		wr_en = 1'b0;
	endtask

	task automatic immediate_formats();
		logic [6:0] ops [8];
		ops = '{7'b0010011, 7'b0000011, 7'b1100111, 7'b0100011,
			7'b1100011, 7'b0110111, 7'b0010111, 7'b1101111};
		for (int o = 0; o < 8; o++) begin
			for (int k = 0; k < 4; k++) begin
				decode_and_compare({25'(rand_bits(25)), ops[o]}, rand_bits(32));
			end
		end
	endtask

	task automatic control_decode();
		logic [6:0] f7s [3];
		logic [6:0] ops [11];
		f7s = '{7'h00, 7'h20, 7'h01};
		ops = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011, 7'b0000011,
			7'b0100011, 7'b1110011, 7'b0001111, 7'b0000000, 7'b1111111};
		for (int f3 = 0; f3 < 8; f3++) begin
			for (int j = 0; j < 3; j++) begin
				decode_and_compare({f7s[j], 5'd5, 5'd6, 3'(f3), 5'd1, 7'b0110011}, 32'h400);
				decode_and_compare({f7s[j], 5'd5, 5'd6, 3'(f3), 5'd1, 7'b0010011}, 32'h404);
			end
			for (int o = 0; o < 11; o++) begin
				decode_and_compare({7'h00, 5'd5, 5'd6, 3'(f3), 5'd1, ops[o]}, 32'h408);
			end
		end
	endtask

	task automatic credit_backpressure();
		int n;
		if_instr = {12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011}; // ADDI x1, x0, 1
		if_pc    = 32'h300;
		if_valid = 1'b1;
		n        = 0;
		for (int c = 0; c < 6; c++) begin
			@(posedge clk);
			#1;
			if (id_valid) n++;
		end
		compare("o_id_valid pulses", 32'(n), 32'd2);
		compare("o_if_stall", 32'(if_stall), 32'd1);
		ex_credit = 1'b1; // One slot freed
		@(posedge clk);
		#1;
		ex_credit = 1'b0;
		n         = 0;
		for (int c = 0; c < 5; c++) begin
			@(posedge clk);
			#1;
			if (id_valid) n++;
		end
		compare("o_id_valid pulses", 32'(n), 32'd1);
		compare("o_if_stall", 32'(if_stall), 32'd1);
		if_valid = 1'b0;
		for (int c = 0; c < 2; c++) begin
			ex_credit = 1'b1; // Drain the two still in execute
			@(posedge clk);
			#1;
		end
		ex_credit = 1'b0;
		compare("o_if_stall", 32'(if_stall), 32'd0);
	endtask

	task automatic credit_stream();
		int   sent;
		int   got;
		int   pending;
		int   cyc;
		logic stalled;
		sent    = 0;
		got     = 0;
		pending = 0; // Held by execute
		for (cyc = 0; cyc < N_STREAM * TIMEOUT && got < N_STREAM; cyc++) begin
			if_valid  = (sent < N_STREAM);
			if_pc     = 32'h1000 + 32'(sent * 4);
			if_instr  = {12'(sent), 5'd0, 3'b000, 5'd1, 7'b0010011}; // Immediate tags the order
			ex_credit = (rand_bits(1) != 0) && (pending > 0);
			stalled   = if_stall;
			@(posedge clk);
			#1;
			if (if_valid && !stalled) sent++;
			if (ex_credit) pending--;
			if (id_valid) begin
				compare("o_pc", pc, 32'h1000 + 32'(got * 4));
				compare("o_imm", imm, 32'(got));
				got++;
				pending++;
			end
		end
		if_valid  = 1'b0;
		ex_credit = 1'b0;
		confirm(got == N_STREAM, "instruction stream did not complete");
		for (cyc = 0; cyc < TIMEOUT && pending > 0; cyc++) begin
			ex_credit = 1'b1;
			@(posedge clk);
			#1;
			pending--;
		end
		ex_credit = 1'b0;
	endtask

	initial begin
		lfsr      = 32'hc4b3b804;
		checks    = 0;
		errors    = 0;
		rst_n     = 1'b0;
		if_instr  = '0;
		if_pc     = '0;
		if_valid  = 1'b0;
		wr_en     = 1'b0;
		wr_addr   = '0;
		wr_data   = '0;
		ex_credit = 1'b0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_state();
		regfile_access();
		immediate_formats();
		control_decode();
		credit_backpressure();
		credit_stream();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
